//--- Makefile
# Verilator build and run for the cache subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_supervisor_cache
RTL_TOP   ?= supervisor_cache_wrapper
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Simulation finished: PASS
SRCS      := $(wildcard hdl/*.sv verif/*.sv)

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- compile.f
hdl/cache_pkg.sv
hdl/icache.sv
hdl/dcache.sv
hdl/bus_arbiter.sv
hdl/memory_controller.sv
hdl/supervisor_cache_wrapper.sv
verif/tb_clock_gen.sv
verif/tb_memory_model.sv
verif/tb_supervisor_cache.sv

//--- hdl/bus_arbiter.sv
/*
  merges the two cache memory-side requests onto one word path
  data cache wins a tie, the loser is held off by its busy
  a grant lasts for exactly one word, released on mc_done
*/
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
  input  logic              CLK,
  input  logic              rst,
  input  cache_pkg::word_t  imem_addr,
  input  logic              imem_ren,
  output cache_pkg::word_t  imem_rdata,
  output logic              imem_busy,
  input  cache_pkg::word_t  dmem_addr,
  input  logic              dmem_ren,
  input  logic              dmem_wen,
  input  cache_pkg::word_t  dmem_wdata,
  output cache_pkg::word_t  dmem_rdata,
  output logic              dmem_busy,
  output logic              dmem_error,
  output cache_pkg::word_t  mc_addr,
  output cache_pkg::word_t  mc_wdata,
  output logic              mc_ren,
  output logic              mc_wen,
  output cache_pkg::grant_t mc_grant,
  input  cache_pkg::word_t  mc_rdata,
  input  logic              mc_done,
  input  logic              mc_error
);
  import cache_pkg::*;

  grant_t grant_q;
  logic   i_req;
  logic   d_req;
  logic   i_own;
  logic   d_own;

  assign i_req = imem_ren;
  assign d_req = dmem_ren || dmem_wen;
  assign i_own = (grant_q == grant_icache);
  assign d_own = (grant_q == grant_dcache);

  // decide in the cycle after a request shows up, hold until the word is done
  always_ff @(posedge CLK) begin
    if (rst) begin
      grant_q <= grant_none;
    end else if (grant_q == grant_none) begin
      if (d_req) grant_q <= grant_dcache;
      else if (i_req) grant_q <= grant_icache;
    end else if (mc_done) begin
      grant_q <= grant_none;
    end
  end

  // owner's request to the controller
  assign mc_addr  = d_own ? dmem_addr : imem_addr;
  assign mc_wdata = dmem_wdata;  // only the data cache writes
  assign mc_ren   = (d_own && dmem_ren) || (i_own && imem_ren);
  assign mc_wen   = d_own && dmem_wen;
  assign mc_grant = grant_q;

  // completion back to the owner only
  assign imem_rdata = i_own ? mc_rdata : '0;
  assign dmem_rdata = d_own ? mc_rdata : '0;
  assign imem_busy  = i_req && !(i_own && mc_done);
  assign dmem_busy  = d_req && !(d_own && mc_done);
  assign dmem_error = d_own && mc_error;

endmodule

`default_nettype wire

//--- hdl/cache_pkg.sv
/*
  geometry of both caches and the owner type of the shared memory path
  all accesses are whole 32-bit words, no byte enables
  direct mapped only, changing num_sets or words_per_line resizes the address fields
*/
`default_nettype none

package cache_pkg;

  localparam int word_width     = 32;
  localparam int words_per_line = 2;   // two-word lines
  localparam int num_sets       = 8;

  // address split: tag | index | word select | byte offset
  localparam int offset_bits = $clog2(words_per_line) + 2;  // 3
  localparam int index_bits  = $clog2(num_sets);            // 3
  localparam int tag_bits    = word_width - index_bits - offset_bits;  // 26

  typedef logic [word_width-1:0] word_t;  // data and address on every bus

  // who owns the memory path right now
  typedef enum logic [1:0] {
    grant_none   = 2'd0,
    grant_icache = 2'd1,
    grant_dcache = 2'd2
  } grant_t;

endpackage

`default_nettype wire

//--- hdl/dcache.sv
/*
  direct-mapped data cache, write-through with no allocate on a write miss
  every write is one word on the memory side, a hit also updates the line
  a fill that saw a bus error returns its data but leaves the line invalid
  requester holds addr, ren or wen and wdata until busy is sampled low
*/
`timescale 1ns/1ps
`default_nettype none

module dcache (
  input  logic             CLK,
  input  logic             rst,
  input  cache_pkg::word_t addr,
  input  logic             ren,
  input  logic             wen,
  input  cache_pkg::word_t wdata,
  output cache_pkg::word_t rdata,
  output logic             busy,
  output logic             miss,
  input  logic             flush,
  output logic             flush_ack,
  output cache_pkg::word_t mem_addr,
  output logic             mem_ren,
  output logic             mem_wen,
  output cache_pkg::word_t mem_wdata,
  input  cache_pkg::word_t mem_rdata,
  input  logic             mem_busy,
  input  logic             mem_error
);
  import cache_pkg::*;

  logic [tag_bits-1:0] tag_q [num_sets];
  word_t               line_q [num_sets][words_per_line];
  logic [num_sets-1:0] valid_q;
  word_t               fill_buf;
  logic                fill_active;
  logic                fill_word;
  logic                wr_active;    // write-through word in flight
  logic                err_q;        // error on word 0 of this fill
  logic                flush_pend;
  logic                flush_ack_q;

  logic [index_bits-1:0] idx;
  logic [tag_bits-1:0]   tag;
  logic                  word_sel;
  logic                  idle;
  logic                  hit_line;
  logic                  rd_hit;
  logic                  fill_done;
  logic                  wr_done;

  assign idx      = addr[offset_bits +: index_bits];
  assign tag      = addr[word_width-1 -: tag_bits];
  assign word_sel = addr[offset_bits-1];

  assign idle      = !fill_active && !wr_active;
  assign hit_line  = valid_q[idx] && (tag_q[idx] == tag);
  assign rd_hit    = ren && hit_line && idle;
  assign fill_done = fill_active && fill_word && !mem_busy;
  assign wr_done   = wr_active && !mem_busy;

  // read miss or write miss, pulsed on the first cycle only
  assign miss  = (ren || wen) && !hit_line && idle;
  assign busy  = (ren && !(rd_hit || fill_done)) || (wen && !wr_done);
  assign rdata = fill_done ? (word_sel ? mem_rdata : fill_buf) : line_q[idx][word_sel];

  assign mem_addr  = wr_active ? addr
                   : {addr[word_width-1:offset_bits], fill_word, {(offset_bits-1){1'b0}}};
  assign mem_ren   = fill_active;
  assign mem_wen   = wr_active;
  assign mem_wdata = wdata;  // held stable by the requester
  assign flush_ack = flush_ack_q;

  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_q     <= '0;
      fill_active <= 1'b0;
      fill_word   <= 1'b0;
      wr_active   <= 1'b0;
      err_q       <= 1'b0;
      flush_pend  <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      flush_ack_q <= 1'b0;
      if (idle) begin
        if (wen) begin
          wr_active <= 1'b1;  // hit or miss, one transfer
        end else if (ren && !hit_line) begin
          fill_active <= 1'b1;
          fill_word   <= 1'b0;
          err_q       <= 1'b0;
        end
      end else if (wr_done) begin
        wr_active <= 1'b0;
      end else if (fill_active && !mem_busy) begin
        if (fill_word) begin
          fill_active  <= 1'b0;
          valid_q[idx] <= !(err_q || mem_error);  // bad line is not kept
        end else begin
          err_q <= mem_error;
        end
        fill_word <= ~fill_word;
      end
      if (flush_pend && idle) begin
        valid_q     <= '0;
        flush_pend  <= 1'b0;
        flush_ack_q <= 1'b1;
      end
      if (flush) flush_pend <= 1'b1;
    end
  end

  // line storage, word update on a write hit once memory took it
  always_ff @(posedge CLK) begin
    if (fill_active && !fill_word && !mem_busy) fill_buf <= mem_rdata;
    if (fill_done) begin
      tag_q[idx]     <= tag;
      line_q[idx][0] <= fill_buf;
      line_q[idx][1] <= mem_rdata;
    end
    if (wr_done && hit_line) line_q[idx][word_sel] <= wdata;
  end

endmodule

`default_nettype wire

//--- hdl/icache.sv
/*
  read-only direct-mapped instruction cache, 8 sets of two-word lines
  hits answer in the same cycle, a miss fetches both words of the line
  requester must hold addr and ren until busy is sampled low
  flush is deferred until a running fill has finished
*/
`timescale 1ns/1ps
`default_nettype none

module icache (
  input  logic             CLK,
  input  logic             rst,
  input  cache_pkg::word_t addr,
  input  logic             ren,
  output cache_pkg::word_t rdata,
  output logic             busy,
  output logic             miss,
  input  logic             flush,
  output logic             flush_ack,
  output cache_pkg::word_t mem_addr,
  output logic             mem_ren,
  input  cache_pkg::word_t mem_rdata,
  input  logic             mem_busy
);
  import cache_pkg::*;

  logic [tag_bits-1:0] tag_q [num_sets];
  word_t               line_q [num_sets][words_per_line];
  logic [num_sets-1:0] valid_q;
  word_t               fill_buf;     // word 0 of the line in flight
  logic                fill_active;
  logic                fill_word;    // which line word is being fetched
  logic                flush_pend;
  logic                flush_ack_q;

  logic [index_bits-1:0] idx;
  logic [tag_bits-1:0]   tag;
  logic                  word_sel;
  logic                  hit;
  logic                  fill_done;

  assign idx      = addr[offset_bits +: index_bits];
  assign tag      = addr[word_width-1 -: tag_bits];
  assign word_sel = addr[offset_bits-1];

  assign hit       = valid_q[idx] && (tag_q[idx] == tag) && !fill_active;
  assign fill_done = fill_active && fill_word && !mem_busy;  // second word landing

  assign miss  = ren && !hit && !fill_active;  // one cycle, fill starts next
  assign busy  = ren && !(hit || fill_done);
  assign rdata = fill_done ? (word_sel ? mem_rdata : fill_buf) : line_q[idx][word_sel];

  // line base plus the word being fetched, byte offset zero
  assign mem_addr  = {addr[word_width-1:offset_bits], fill_word, {(offset_bits-1){1'b0}}};
  assign mem_ren   = fill_active;
  assign flush_ack = flush_ack_q;

  always_ff @(posedge CLK) begin
    if (rst) begin
      valid_q     <= '0;
      fill_active <= 1'b0;
      fill_word   <= 1'b0;
      flush_pend  <= 1'b0;
      flush_ack_q <= 1'b0;
    end else begin
      flush_ack_q <= 1'b0;
      if (miss) begin
        fill_active <= 1'b1;
        fill_word   <= 1'b0;
      end else if (fill_active && !mem_busy) begin
        if (fill_word) begin
          fill_active  <= 1'b0;
          valid_q[idx] <= 1'b1;
        end
        fill_word <= ~fill_word;
      end
      // invalidate only between fills
      if (flush_pend && !fill_active) begin
        valid_q     <= '0;
        flush_pend  <= 1'b0;
        flush_ack_q <= 1'b1;
      end
      if (flush) flush_pend <= 1'b1;  // after the clear so a back-to-back flush is kept
    end
  end

  // line storage
  always_ff @(posedge CLK) begin
    if (fill_active && !fill_word && !mem_busy) fill_buf <= mem_rdata;
    if (fill_done) begin
      tag_q[idx]     <= tag;
      line_q[idx][0] <= fill_buf;
      line_q[idx][1] <= mem_rdata;
    end
  end

endmodule

`default_nettype wire

//--- hdl/memory_controller.sv
/*
  puts one granted word on the external bus and reports its completion
  strobe rises the cycle after the grant, mc_done one cycle after the last edge
  bus_error is sticky until rst
*/
`timescale 1ns/1ps
`default_nettype none

module memory_controller (
  input  logic              CLK,
  input  logic              rst,
  input  cache_pkg::word_t  mc_addr,
  input  cache_pkg::word_t  mc_wdata,
  input  logic              mc_ren,
  input  logic              mc_wen,
  input  cache_pkg::grant_t mc_grant,
  output cache_pkg::word_t  mc_rdata,
  output logic              mc_done,
  output logic              mc_error,
  output logic              bus_error,
  output cache_pkg::word_t  out_addr,
  output cache_pkg::word_t  out_wdata,
  output logic              out_ren,
  output logic              out_wen,
  input  cache_pkg::word_t  out_rdata,
  input  logic              out_busy,
  input  logic              out_error
);
  import cache_pkg::*;

  grant_t grant_prev;   // grant seen last cycle
  logic   active;       // idle / active
  logic   ren_q;
  logic   wen_q;
  word_t  addr_q;
  word_t  wdata_q;
  word_t  rdata_q;
  logic   done_q;
  logic   err_q;
  logic   bus_error_q;
  logic   start;
  logic   finish;

  assign start  = (mc_grant != grant_none) && (grant_prev == grant_none);  // new grant
  assign finish = active && !out_busy;  // strobe high and memory ready

  always_ff @(posedge CLK) begin
    if (rst) begin
      grant_prev  <= grant_none;
      active      <= 1'b0;
      ren_q       <= 1'b0;
      wen_q       <= 1'b0;
      done_q      <= 1'b0;
      err_q       <= 1'b0;
      bus_error_q <= 1'b0;
    end else begin
      grant_prev <= mc_grant;
      done_q     <= finish;
      err_q      <= finish && out_error;
      if (start) begin
        active <= 1'b1;
        ren_q  <= mc_ren;
        wen_q  <= mc_wen;
      end else if (finish) begin
        active <= 1'b0;
        ren_q  <= 1'b0;
        wen_q  <= 1'b0;
      end
      if (finish && out_error) bus_error_q <= 1'b1;
    end
  end

  // request and returned word
  always_ff @(posedge CLK) begin
    if (start) begin
      addr_q  <= mc_addr;
      wdata_q <= mc_wdata;
    end
    if (finish) rdata_q <= out_rdata;
  end

  assign out_addr  = addr_q;
  assign out_wdata = wdata_q;
  assign out_ren   = active && ren_q;
  assign out_wen   = active && wen_q;
  assign mc_rdata  = rdata_q;
  assign mc_done   = done_q;
  assign mc_error  = err_q;
  assign bus_error = bus_error_q;

endmodule

`default_nettype wire

//--- hdl/supervisor_cache_wrapper.sv
/*
  one-hart memory subsystem: I and D caches, arbiter and controller
  processor side buses use busy-level handshakes, reads hit in zero wait states
  flush_done pulses once both caches have invalidated
*/
`timescale 1ns/1ps
`default_nettype none

module supervisor_cache_wrapper (
  input  logic             CLK,
  input  logic             rst,
  input  cache_pkg::word_t icache_addr,
  input  logic             icache_ren,
  output cache_pkg::word_t icache_rdata,
  output logic             icache_busy,
  input  cache_pkg::word_t dcache_addr,
  input  logic             dcache_ren,
  input  logic             dcache_wen,
  input  cache_pkg::word_t dcache_wdata,
  output cache_pkg::word_t dcache_rdata,
  output logic             dcache_busy,
  output logic             icache_miss,
  output logic             dcache_miss,
  input  logic             flush,
  output logic             flush_done,
  output logic             bus_error,
  output cache_pkg::word_t out_addr,
  output cache_pkg::word_t out_wdata,
  output logic             out_ren,
  output logic             out_wen,
  input  cache_pkg::word_t out_rdata,
  input  logic             out_busy,
  input  logic             out_error
);
  import cache_pkg::*;

  word_t  imem_addr, imem_rdata;
  logic   imem_ren, imem_busy;
  word_t  dmem_addr, dmem_wdata, dmem_rdata;
  logic   dmem_ren, dmem_wen, dmem_busy, dmem_error;
  word_t  mc_addr, mc_wdata, mc_rdata;
  logic   mc_ren, mc_wen, mc_done, mc_error;
  grant_t mc_grant;
  logic   iflush_ack, dflush_ack;
  logic   i_seen, d_seen;  // ack already arrived from that side

  // normally both acks come on the same cycle, a fill on one side can skew them
  assign flush_done = (iflush_ack || i_seen) && (dflush_ack || d_seen);

  always_ff @(posedge CLK) begin
    if (rst || flush_done) begin
      i_seen <= 1'b0;
      d_seen <= 1'b0;
    end else begin
      if (iflush_ack) i_seen <= 1'b1;
      if (dflush_ack) d_seen <= 1'b1;
    end
  end

  icache icache_i (
    .CLK(CLK), .rst(rst),
    .addr(icache_addr), .ren(icache_ren), .rdata(icache_rdata), .busy(icache_busy),
    .miss(icache_miss), .flush(flush), .flush_ack(iflush_ack),
    .mem_addr(imem_addr), .mem_ren(imem_ren), .mem_rdata(imem_rdata), .mem_busy(imem_busy)
  );

  dcache dcache_i (
    .CLK(CLK), .rst(rst),
    .addr(dcache_addr), .ren(dcache_ren), .wen(dcache_wen), .wdata(dcache_wdata),
    .rdata(dcache_rdata), .busy(dcache_busy), .miss(dcache_miss),
    .flush(flush), .flush_ack(dflush_ack),
    .mem_addr(dmem_addr), .mem_ren(dmem_ren), .mem_wen(dmem_wen), .mem_wdata(dmem_wdata),
    .mem_rdata(dmem_rdata), .mem_busy(dmem_busy), .mem_error(dmem_error)
  );

  bus_arbiter arbiter_i (
    .CLK(CLK), .rst(rst),
    .imem_addr(imem_addr), .imem_ren(imem_ren), .imem_rdata(imem_rdata),
    .imem_busy(imem_busy),
    .dmem_addr(dmem_addr), .dmem_ren(dmem_ren), .dmem_wen(dmem_wen),
    .dmem_wdata(dmem_wdata), .dmem_rdata(dmem_rdata), .dmem_busy(dmem_busy),
    .dmem_error(dmem_error),
    .mc_addr(mc_addr), .mc_wdata(mc_wdata), .mc_ren(mc_ren), .mc_wen(mc_wen),
    .mc_grant(mc_grant), .mc_rdata(mc_rdata), .mc_done(mc_done), .mc_error(mc_error)
  );

  memory_controller mc_i (
    .CLK(CLK), .rst(rst),
    .mc_addr(mc_addr), .mc_wdata(mc_wdata), .mc_ren(mc_ren), .mc_wen(mc_wen),
    .mc_grant(mc_grant), .mc_rdata(mc_rdata), .mc_done(mc_done), .mc_error(mc_error),
    .bus_error(bus_error),
    .out_addr(out_addr), .out_wdata(out_wdata), .out_ren(out_ren), .out_wen(out_wen),
    .out_rdata(out_rdata), .out_busy(out_busy), .out_error(out_error)
  );

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
/*
  free-running testbench clock with a 4 ns period
  rst is high from time zero for reset_cycles rising edges
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int half_period  = 2,  // ns
  parameter int reset_cycles = 5
) (
  output logic CLK,
  output logic rst
);

  initial begin
    CLK = 1'b0;
    forever #(half_period) CLK = ~CLK;
  end

  initial begin
    rst = 1'b1;
    repeat (reset_cycles) @(posedge CLK);
    rst <= 1'b0;  // released on a rising edge
  end

endmodule

`default_nettype wire

//--- verif/tb_memory_model.sv
/*
  word-wide external memory, unwritten words read as addr ^ fill_xor
  busy is held for latency cycles of every strobe, then the transfer completes
  only the low 64 KiB are backed, higher addresses alias onto it
*/
`timescale 1ns/1ps
`default_nettype none

module tb_memory_model #(
  parameter int               latency  = 3,
  parameter cache_pkg::word_t fill_xor = 32'h5a5a_0000,
  parameter cache_pkg::word_t err_lo   = 32'h0000_f000,
  parameter cache_pkg::word_t err_hi   = 32'h0000_f0ff
) (
  input  logic             CLK,
  input  logic             rst,
  input  cache_pkg::word_t out_addr,
  input  cache_pkg::word_t out_wdata,
  input  logic             out_ren,
  input  logic             out_wen,
  output cache_pkg::word_t out_rdata,
  output logic             out_busy,
  output logic             out_error
);
  import cache_pkg::*;

  localparam int depth = 16384;  // words in 64 KiB

  word_t            data_q [depth];
  logic [depth-1:0] written_q;  // word stored at least once
  int               wait_q;     // busy cycles already given
  logic             strobe;
  logic [13:0]      widx;

  assign strobe    = out_ren || out_wen;
  assign widx      = out_addr[15:2];
  assign out_busy  = !rst && strobe && (wait_q != latency);
  assign out_error = !rst && strobe && (out_addr >= err_lo) && (out_addr <= err_hi);
  // data still comes back on an error
  assign out_rdata = rst ? '0 : (written_q[widx] ? data_q[widx] : (out_addr ^ fill_xor));

  always_ff @(posedge CLK) begin
    if (rst) begin
      wait_q    <= 0;
      written_q <= '0;
    end else if (out_busy) begin
      wait_q <= wait_q + 1;
    end else begin
      wait_q <= 0;
      if (out_wen) begin  // completing edge of a write
        written_q[widx] <= 1'b1;
        data_q[widx]    <= out_wdata;
      end
    end
  end

endmodule

`default_nettype wire

//--- verif/tb_supervisor_cache.sv
/*
  directed tests for the cache subsystem, all addresses stay in the low 64 KiB
  memory words read as addr ^ 5a5a_0000 until written, a shadow copy tracks writes
  addresses and data from a 32-bit Galois LFSR with a fixed seed
  the bus error test runs last since bus_error only clears on rst
*/
`timescale 1ns/1ps
`default_nettype none

module tb_supervisor_cache;
  import cache_pkg::*;

  localparam int          mem_latency  = 3;  // busy cycles per transfer
  localparam word_t       fill_xor     = 32'h5a5a_0000;
  localparam word_t       err_lo       = 32'h0000_f000;  // tags 10'h3c0 to 10'h3c3
  localparam word_t       err_hi       = 32'h0000_f0ff;
  localparam logic [31:0] lfsr_seed    = 32'h82a9_2f06;
  localparam int          reset_cycles = 5;
  // read miss: two words of arbitration, strobe and done, plus task overhead
  localparam int access_cycles  = 2 * (mem_latency + 4) + 4;
  // accesses per test 3, 7, 4, 2, 6, 2 plus the flush wait and reset
  localparam int worst_cycles   = (3 + 7 + 4 + 2 + 6 + 2) * access_cycles + 8 + reset_cycles;
  localparam int timeout_cycles = 2 * worst_cycles;

  logic  CLK, rst;
  word_t icache_addr, icache_rdata;
  logic  icache_ren, icache_busy, icache_miss;
  word_t dcache_addr, dcache_wdata, dcache_rdata;
  logic  dcache_ren, dcache_wen, dcache_busy, dcache_miss;
  logic  flush, flush_done, bus_error;
  word_t out_addr, out_wdata, out_rdata;
  logic  out_ren, out_wen, out_busy, out_error;

  word_t          shadow_data [16384];  // expected memory, written words only
  logic [16383:0] shadow_written;
  logic [31:0]    lfsr_q;
  int             imiss_cnt, dmiss_cnt, fdone_cnt;
  int             errors, checks, tests, cycle_cnt;

  tb_clock_gen #(.half_period(2), .reset_cycles(reset_cycles)) clock_i (.CLK(CLK), .rst(rst));

  tb_memory_model #(
    .latency(mem_latency), .fill_xor(fill_xor), .err_lo(err_lo), .err_hi(err_hi)
  ) memory_i (
    .CLK(CLK), .rst(rst),
    .out_addr(out_addr), .out_wdata(out_wdata), .out_ren(out_ren), .out_wen(out_wen),
    .out_rdata(out_rdata), .out_busy(out_busy), .out_error(out_error)
  );

  supervisor_cache_wrapper dut_i (
    .CLK(CLK), .rst(rst),
    .icache_addr(icache_addr), .icache_ren(icache_ren), .icache_rdata(icache_rdata),
    .icache_busy(icache_busy),
    .dcache_addr(dcache_addr), .dcache_ren(dcache_ren), .dcache_wen(dcache_wen),
    .dcache_wdata(dcache_wdata), .dcache_rdata(dcache_rdata), .dcache_busy(dcache_busy),
    .icache_miss(icache_miss), .dcache_miss(dcache_miss),
    .flush(flush), .flush_done(flush_done), .bus_error(bus_error),
    .out_addr(out_addr), .out_wdata(out_wdata), .out_ren(out_ren), .out_wen(out_wen),
    .out_rdata(out_rdata), .out_busy(out_busy), .out_error(out_error)
  );

  // one-cycle pulses counted here, access tasks take the difference
  always @(posedge CLK) begin
    if (rst) begin
      imiss_cnt <= 0;
      dmiss_cnt <= 0;
      fdone_cnt <= 0;
    end else begin
      if (icache_miss) imiss_cnt <= imiss_cnt + 1;
      if (dcache_miss) dmiss_cnt <= dmiss_cnt + 1;
      if (flush_done) fdone_cnt <= fdone_cnt + 1;
    end
  end

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);  // taps 32 22 2 1
  endfunction

  task automatic take_bits(input int n, output word_t v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      v[i]   = lfsr_q[0];
      lfsr_q = lfsr_next(lfsr_q);  // one step per bit
    end
  endtask

  // random index and word inside the given tag
  task automatic rand_addr(input logic [9:0] tag, output word_t a);
    word_t r;
    take_bits(4, r);
    a = {16'h0000, tag, r[2:0], r[3], 2'b00};
  endtask

  function automatic word_t expected_word(input word_t a);
    if (shadow_written[a[15:2]]) return shadow_data[a[15:2]];
    return a ^ fill_xor;
  endfunction

  task automatic shadow_write(input word_t a, input word_t w);
    shadow_data[a[15:2]]    = w;
    shadow_written[a[15:2]] = 1'b1;
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0d ns %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0d ns %s: got %b, expected %b", $time, name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0d ns %s: got %0d, expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests++;
    if (errors == errors_before) $display("test %0d %s: ok", tests, name);
    else $display("test %0d %s: %0d errors", tests, name, errors - errors_before);
  endtask

  // hold ren until busy is sampled low, misses counted over the whole access
  task automatic icache_read(input word_t a, output word_t d, output int misses);
    int first;
    @(posedge CLK);
    first = imiss_cnt;
    icache_addr <= a;
    icache_ren  <= 1'b1;
    @(posedge CLK);
    while (icache_busy) @(posedge CLK);
    d = icache_rdata;
    icache_ren <= 1'b0;
    @(posedge CLK);  // let the last pulse land in the counter
    misses = imiss_cnt - first;
  endtask

  task automatic dcache_read(input word_t a, output word_t d, output int misses);
    int first;
    @(posedge CLK);
    first = dmiss_cnt;
    dcache_addr <= a;
    dcache_ren  <= 1'b1;
    @(posedge CLK);
    while (dcache_busy) @(posedge CLK);
    d = dcache_rdata;
    dcache_ren <= 1'b0;
    @(posedge CLK);
    misses = dmiss_cnt - first;
  endtask

  task automatic dcache_write(input word_t a, input word_t w, output int misses);
    int first;
    @(posedge CLK);
    first = dmiss_cnt;
    dcache_addr  <= a;
    dcache_wdata <= w;
    dcache_wen   <= 1'b1;
    @(posedge CLK);
    while (dcache_busy) @(posedge CLK);
    dcache_wen <= 1'b0;
    @(posedge CLK);
    misses = dmiss_cnt - first;
  endtask

  task automatic pulse_flush(output int wait_cycles, output int pulses);
    int first;
    @(posedge CLK);
    first = fdone_cnt;
    flush <= 1'b1;
    @(posedge CLK);
    flush       <= 1'b0;
    wait_cycles = 0;
    while (!flush_done) begin
      @(posedge CLK);
      wait_cycles++;
    end
    repeat (3) @(posedge CLK);  // room for a stray second pulse
    pulses = fdone_cnt - first;
  endtask

  task automatic test_ifetch();
    word_t a, d;
    int    m, e0;
    e0 = errors;
    rand_addr(10'h011, a);
    icache_read(a, d, m);
    check_count("icache_miss cold", m, 1);
    check_word("icache_rdata", d, expected_word(a));
    icache_read(a, d, m);
    check_count("icache_miss repeat", m, 0);
    check_word("icache_rdata", d, expected_word(a));
    icache_read(a ^ 32'h4, d, m);  // other word of the line
    check_count("icache_miss other word", m, 0);
    check_word("icache_rdata", d, expected_word(a ^ 32'h4));
    report_test("instruction fetch", e0);
  endtask

  task automatic test_write_through();
    word_t a, b, w1, w2, d;
    int    m, e0;
    e0 = errors;
    rand_addr(10'h022, a);
    take_bits(32, w1);
    dcache_read(a, d, m);  // bring the line in first
    check_count("dcache_miss fill", m, 1);
    check_word("dcache_rdata", d, expected_word(a));
    dcache_write(a, w1, m);
    shadow_write(a, w1);
    check_count("dcache_miss write hit", m, 0);
    dcache_read(a, d, m);
    check_count("dcache_miss after write hit", m, 0);
    check_word("dcache_rdata", d, expected_word(a));
    rand_addr(10'h033, b);
    take_bits(32, w2);
    dcache_write(b, w2, m);  // no allocate
    shadow_write(b, w2);
    check_count("dcache_miss write miss", m, 1);
    dcache_read(b, d, m);
    check_count("dcache_miss after write miss", m, 1);
    check_word("dcache_rdata", d, expected_word(b));
    // memory itself, seen from cold icache lines
    icache_read(b, d, m);
    check_count("icache_miss cold", m, 1);
    check_word("icache_rdata", d, expected_word(b));
    icache_read(a, d, m);
    check_count("icache_miss cold", m, 1);
    check_word("icache_rdata", d, expected_word(a));
    report_test("data write-through", e0);
  endtask

  task automatic test_conflict();
    word_t a, b, r, d;
    int    m, e0, k;
    e0 = errors;
    rand_addr(10'h044, a);
    take_bits(1, r);
    b = {16'h0000, 10'h055, a[5:3], r[0], 2'b00};  // same index, other tag
    for (k = 0; k < 2; k++) begin
      dcache_read(a, d, m);
      check_count("dcache_miss conflict a", m, 1);
      check_word("dcache_rdata", d, expected_word(a));
      dcache_read(b, d, m);
      check_count("dcache_miss conflict b", m, 1);
      check_word("dcache_rdata", d, expected_word(b));
    end
    report_test("conflict eviction", e0);
  endtask

  task automatic test_concurrent();
    word_t ia, da, id, dd;
    int    im, dm, e0;
    e0 = errors;
    rand_addr(10'h066, ia);
    rand_addr(10'h077, da);
    fork  // both present on the same edge
      icache_read(ia, id, im);
      dcache_read(da, dd, dm);
    join
    check_count("icache_miss", im, 1);
    check_word("icache_rdata", id, expected_word(ia));
    check_count("dcache_miss", dm, 1);
    check_word("dcache_rdata", dd, expected_word(da));
    report_test("concurrent misses", e0);
  endtask

  task automatic test_flush();
    word_t ia, da, d;
    int    m, lat, pulses, e0;
    e0 = errors;
    rand_addr(10'h088, ia);
    rand_addr(10'h099, da);
    icache_read(ia, d, m);
    check_count("icache_miss fill", m, 1);
    dcache_read(da, d, m);
    check_count("dcache_miss fill", m, 1);
    icache_read(ia, d, m);
    check_count("icache_miss cached", m, 0);
    dcache_read(da, d, m);
    check_count("dcache_miss cached", m, 0);
    pulse_flush(lat, pulses);
    check_count("flush_done latency", lat, 2);
    check_count("flush_done pulses", pulses, 1);
    icache_read(ia, d, m);
    check_count("icache_miss after flush", m, 1);
    check_word("icache_rdata", d, expected_word(ia));
    dcache_read(da, d, m);
    check_count("dcache_miss after flush", m, 1);
    check_word("dcache_rdata", d, expected_word(da));
    report_test("flush", e0);
  endtask

  task automatic test_bus_error();
    word_t a, d;
    int    m, e0;
    e0 = errors;
    @(posedge CLK);
    check_flag("bus_error before", bus_error, 1'b0);
    rand_addr(10'h3c0, a);  // inside err_lo..err_hi
    dcache_read(a, d, m);
    check_count("dcache_miss error read", m, 1);
    check_word("dcache_rdata", d, expected_word(a));
    check_flag("bus_error", bus_error, 1'b1);
    dcache_read(a, d, m);  // line was dropped
    check_count("dcache_miss repeat error read", m, 1);
    check_word("dcache_rdata", d, expected_word(a));
    check_flag("bus_error sticky", bus_error, 1'b1);
    report_test("bus error", e0);
  endtask

  initial begin
    icache_addr    = '0;
    icache_ren     = 1'b0;
    dcache_addr    = '0;
    dcache_ren     = 1'b0;
    dcache_wen     = 1'b0;
    dcache_wdata   = '0;
    flush          = 1'b0;
    shadow_written = '0;
    lfsr_q         = lfsr_seed;
    errors         = 0;
    checks         = 0;
    tests          = 0;
    @(posedge CLK);
    while (rst !== 1'b0) @(posedge CLK);
    test_ifetch();
    test_write_through();
    test_conflict();
    test_concurrent();
    test_flush();
    test_bus_error();
    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  // watchdog on a stuck handshake
  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < timeout_cycles) begin
      @(posedge CLK);
      cycle_cnt++;
    end
    $display("timeout: tests did not finish within %0d cycles", timeout_cycles);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
